// ==== cu_setup.f ====
+incdir+include
hdl/cu_setup_pkg.sv
hdl/req_stream_if.sv
hdl/setup_ctrl.sv
hdl/serial_read_engine.sv
hdl/request_fifo.sv
hdl/cu_setup_top.sv
verif/tb_clock_gen.sv
verif/cu_setup_tb.sv

// ==== verif/cu_setup_tb.sv ====
/*
 * Descriptor table testbench for cu_setup_top. Outputs are sampled on the
 * rising edge, so they are seen as they were before that edge.
 */
`include "cu_setup_consts.svh"

module cu_setup_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_DESC       = 8;
    localparam int RESET_TIMEOUT  = 20;
    localparam int ACCEPT_TIMEOUT = 1000;

    typedef struct packed {
        logic [`CU_SETUP_ADDR_W-1:0]  base;
        logic [`CU_SETUP_COUNT_W-1:0] count;
        logic [7:0]                   ready_pct;
    } desc_entry_t;

    logic                         ap_clk;
    logic                         areset_cu_setup;
    logic                         desc_valid;
    logic                         desc_ready;
    logic [`CU_SETUP_ADDR_W-1:0]  desc_base;
    logic [`CU_SETUP_COUNT_W-1:0] desc_count;
    logic                         req_valid;
    logic                         req_ready;
    logic [`CU_SETUP_ADDR_W-1:0]  req_addr;
    logic [`CU_SETUP_COUNT_W-1:0] req_tag;
    logic                         setup_busy;

    desc_entry_t                  desc_table [NUM_DESC];
    logic [`CU_SETUP_ADDR_W-1:0]  exp_addr_q [$];
    logic [`CU_SETUP_COUNT_W-1:0] exp_tag_q [$];
    int                           got_total;

    tb_clock_gen clk_gen (
        .ap_clk          (ap_clk),
        .areset_cu_setup (areset_cu_setup)
    );

    cu_setup_top dut0 (
        .ap_clk          (ap_clk),
        .areset_cu_setup (areset_cu_setup),
        .desc_valid      (desc_valid),
        .desc_ready      (desc_ready),
        .desc_base       (desc_base),
        .desc_count      (desc_count),
        .req_valid       (req_valid),
        .req_ready       (req_ready),
        .req_addr        (req_addr),
        .req_tag         (req_tag),
        .setup_busy      (setup_busy)
    );

    task automatic stop_with_failure(input string reason);
        $display("%s", reason);
        $display("*** TEST FAILED ***");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic check_value(input logic [63:0] actual, input logic [63:0] expected,
                               input string what);
        if (actual !== expected) begin
            stop_with_failure($sformatf("CHECK FAILED at %0d ns: %s (got 0x%0h, expected 0x%0h)",
                                        $time, what, actual, expected));
        end
    endtask

    // ------------------------------------------------------------------
    // Request monitor and reference model
    // ------------------------------------------------------------------
    initial begin : monitor
        int                           acc_idx;
        int                           cur_pct;
        int                           i;
        int                           since_last;
        logic                         busy_exp;
        logic                         held;
        logic [`CU_SETUP_ADDR_W-1:0]  held_addr;
        logic [`CU_SETUP_COUNT_W-1:0] held_tag;
        void'($urandom(32'hfece_b4ec));
        acc_idx    = 0;
        cur_pct    = 100;
        held       = 1'b0;
        busy_exp   = 1'b1;
        since_last = -1;
        forever begin
            @(posedge ap_clk);
            if (areset_cu_setup !== 1'b0) begin
                held       = 1'b0;
                busy_exp   = 1'b1;
                since_last = -1;
            end else begin
                // A stalled request keeps its payload
                if (held) begin
                    check_value(req_valid, 1'b1, "req_valid dropped before transfer");
                    check_value(req_addr, held_addr, "req_addr changed while stalled");
                    check_value(req_tag, held_tag, "req_tag changed while stalled");
                end
                if (req_valid && req_ready) begin
                    if (exp_addr_q.size() == 0) begin
                        stop_with_failure($sformatf("Unexpected request at %0d ns, tag %0d",
                                                    $time, req_tag));
                    end
                    check_value(req_addr, exp_addr_q.pop_front(), "request address");
                    check_value(req_tag, exp_tag_q.pop_front(), "request tag");
                    got_total++;
                    if (exp_addr_q.size() == 0) begin
                        since_last = 0;
                    end
                end
                held      = req_valid && !req_ready;
                held_addr = req_addr;
                held_tag  = req_tag;

                // Busy from acceptance until desc_ready returns
                if (!busy_exp) begin
                    check_value(desc_ready, 1'b1, "desc_ready while idle");
                    check_value(setup_busy, 1'b0, "setup_busy while idle");
                end else if (desc_ready) begin
                    check_value(exp_addr_q.size(), 0, "desc_ready with requests outstanding");
                    check_value(setup_busy, 1'b0, "setup_busy once desc_ready returns");
                    busy_exp = 1'b0;
                end else begin
                    check_value(setup_busy, 1'b1, "setup_busy while working");
                    if (since_last > 2) begin
                        stop_with_failure({"Timeout: desc_ready did not return within ",
                                           "2 cycles of the last request"});
                    end
                    if (since_last >= 0) begin
                        since_last++;
                    end
                end

                // Expected requests of a newly accepted descriptor
                if (desc_valid && desc_ready) begin
                    for (i = 0; i < int'(desc_count); i++) begin
                        exp_addr_q.push_back(desc_base +
                            (`CU_SETUP_ADDR_W'(i) << `CU_SETUP_WORD_SHIFT));
                        exp_tag_q.push_back(`CU_SETUP_COUNT_W'(i));
                    end
                    if (acc_idx < NUM_DESC) begin
                        cur_pct = int'(desc_table[acc_idx].ready_pct);
                    end
                    acc_idx++;
                    busy_exp   = 1'b1;
                    since_last = -1;
                end
                req_ready <= (int'($urandom % 100) < cur_pct);
            end
        end
    end

    // ------------------------------------------------------------------
    // Descriptor stimulus
    // ------------------------------------------------------------------
    initial begin : stimulus
        int n;
        int wait_cycles;
        int expected_total;
        desc_valid     = 1'b0;
        desc_base      = '0;
        desc_count     = '0;
        req_ready      = 1'b0;
        got_total      = 0;
        expected_total = 0;

        // Base, word count, req_ready percentage
        desc_table[0] = '{32'h0000_1000, 16'd1, 8'd100};
        desc_table[1] = '{32'h0000_2000, 16'd5, 8'd100};
        desc_table[2] = '{32'h0001_0000, 16'd0, 8'd100};
        desc_table[3] = '{32'h0002_0040, 16'd40, 8'd50};
        desc_table[4] = '{32'hffff_fff0, 16'd5, 8'd75};
        desc_table[5] = '{32'h0000_3000, 16'd40, 8'd50};
        desc_table[6] = '{32'h0000_4000, 16'd0, 8'd100};
        desc_table[7] = '{32'h0000_5004, 16'd3, 8'd25};

        // First edge applies reset, later edges see its values
        @(posedge ap_clk);
        wait_cycles = 0;
        forever begin
            @(posedge ap_clk);
            if (!areset_cu_setup) break;
            check_value(req_valid, 1'b0, "req_valid during reset");
            check_value(desc_ready, 1'b0, "desc_ready during reset");
            check_value(setup_busy, 1'b1, "setup_busy during reset");
            wait_cycles++;
            if (wait_cycles >= RESET_TIMEOUT) begin
                stop_with_failure("Timeout: reset was never released");
            end
        end
        @(posedge ap_clk);
        check_value(desc_ready, 1'b1, "desc_ready after reset");
        check_value(setup_busy, 1'b0, "setup_busy after reset");

        // Next descriptor stays valid while the previous one runs
        for (n = 0; n < NUM_DESC; n++) begin
            desc_valid     <= 1'b1;
            desc_base      <= desc_table[n].base;
            desc_count     <= desc_table[n].count;
            expected_total += int'(desc_table[n].count);
            wait_cycles    = 0;
            forever begin
                @(posedge ap_clk);
                if (desc_valid && desc_ready) break;
                wait_cycles++;
                if (wait_cycles >= ACCEPT_TIMEOUT) begin
                    stop_with_failure($sformatf("Timeout: descriptor %0d was not accepted", n));
                end
            end
        end
        desc_valid <= 1'b0;

        // Last descriptor done once desc_ready returns
        wait_cycles = 0;
        forever begin
            @(posedge ap_clk);
            if (desc_ready) break;
            wait_cycles++;
            if (wait_cycles >= ACCEPT_TIMEOUT) begin
                stop_with_failure("Timeout: desc_ready did not return after the last descriptor");
            end
        end
        @(negedge ap_clk);
        check_value(exp_addr_q.size(), 0, "requests still expected at end");
        check_value(got_total, expected_total, "total request count");

        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule : cu_setup_tb

// ==== verif/tb_clock_gen.sv ====
/*
 * 40 ns clock, free running from time zero. Reset is high for the first
 * three rising edges and falls after the third.
 */
module tb_clock_gen (
    output logic ap_clk,
    output logic areset_cu_setup
);

    timeunit 1ns;
    timeprecision 1ps;

    localparam int HALF_PERIOD = 20;

    initial begin
        ap_clk = 1'b0;
        forever #HALF_PERIOD ap_clk = ~ap_clk;
    end

    initial begin
        areset_cu_setup = 1'b1;
        repeat (3) @(posedge ap_clk);
        areset_cu_setup <= 1'b0;
    end

endmodule : tb_clock_gen

// ==== hdl/cu_setup_top.sv ====
/*
 * Setup stage top. First request follows acceptance by at least 3 clocks.
 */
`include "cu_setup_consts.svh"

module cu_setup_top (
    input  logic                         ap_clk,
    input  logic                         areset_cu_setup,
    input  logic                         desc_valid,
    output logic                         desc_ready,
    input  logic [`CU_SETUP_ADDR_W-1:0]  desc_base,
    input  logic [`CU_SETUP_COUNT_W-1:0] desc_count,
    output logic                         req_valid,
    input  logic                         req_ready,
    output logic [`CU_SETUP_ADDR_W-1:0]  req_addr,
    output logic [`CU_SETUP_COUNT_W-1:0] req_tag,
    output logic                         setup_busy
);

    logic                         eng_start;
    logic [`CU_SETUP_ADDR_W-1:0]  eng_base;
    logic [`CU_SETUP_COUNT_W-1:0] eng_count;
    logic                         eng_pause;
    logic                         engine_done;
    logic                         fifo_almost_full;
    logic                         fifo_empty;
    cu_setup_pkg::read_req_t      fifo_data;

    req_stream_if req_if ();

    setup_ctrl u_ctrl (
        .ap_clk           (ap_clk),
        .areset_cu_setup  (areset_cu_setup),
        .desc_valid       (desc_valid),
        .desc_ready       (desc_ready),
        .desc_base        (desc_base),
        .desc_count       (desc_count),
        .eng_start        (eng_start),
        .eng_base         (eng_base),
        .eng_count        (eng_count),
        .eng_pause        (eng_pause),
        .engine_done      (engine_done),
        .fifo_almost_full (fifo_almost_full),
        .fifo_empty       (fifo_empty),
        .setup_busy       (setup_busy)
    );

    serial_read_engine u_engine (
        .ap_clk          (ap_clk),
        .areset_cu_setup (areset_cu_setup),
        .start           (eng_start),
        .pause           (eng_pause),
        .base            (eng_base),
        .count           (eng_count),
        .engine_done     (engine_done),
        .req             (req_if.source)
    );

    request_fifo #(
        .DEPTH (`CU_SETUP_FIFO_DEPTH)
    ) u_fifo (
        .ap_clk          (ap_clk),
        .areset_cu_setup (areset_cu_setup),
        .wr              (req_if.sink),
        .rd_valid        (req_valid),
        .rd_ready        (req_ready),
        .rd_data         (fifo_data),
        .almost_full     (fifo_almost_full),
        .empty           (fifo_empty)
    );

    // Split payload onto the request ports
    assign req_addr = fifo_data.addr;
    assign req_tag  = fifo_data.tag;

endmodule : cu_setup_top

// ==== hdl/request_fifo.sv ====
/*
 * First-word fall-through request FIFO. DEPTH need not be a power of two.
 * almost_full rises at the shared threshold, which must stay below DEPTH.
 */
`include "cu_setup_consts.svh"

module request_fifo #(
    parameter int DEPTH = `CU_SETUP_FIFO_DEPTH
) (
    input  logic                    ap_clk,
    input  logic                    areset_cu_setup,
    req_stream_if.sink              wr,
    output logic                    rd_valid,
    input  logic                    rd_ready,
    output cu_setup_pkg::read_req_t rd_data,
    output logic                    almost_full,
    output logic                    empty
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    cu_setup_pkg::read_req_t mem [DEPTH];
    logic [PTR_W-1:0]        wr_ptr;
    logic [PTR_W-1:0]        rd_ptr;
    logic [CNT_W-1:0]        count_q;
    logic                    full;
    logic                    wr_en;
    logic                    rd_en;

    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
        return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    // ----------------------------------------------------------------------
    // Flags and handshakes
    // ----------------------------------------------------------------------
    assign full        = (count_q == CNT_W'(DEPTH));
    assign empty       = (count_q == '0);
    assign almost_full = (count_q >= CNT_W'(`CU_SETUP_FIFO_THRESH));
    assign wr.ready    = !full;
    assign wr_en       = wr.valid && wr.ready;
    assign rd_valid    = !empty;
    assign rd_en       = rd_valid && rd_ready;
    assign rd_data     = mem[rd_ptr];

    // Storage
    always_ff @(posedge ap_clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= wr.payload;
        end
    end

    // Pointers and occupancy
    always_ff @(posedge ap_clk) begin
        if (areset_cu_setup) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            count_q <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (rd_en) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            case ({wr_en, rd_en})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    // ----------------------------------------------------------------------
    // Assertions
    // ----------------------------------------------------------------------
    // Pause latency leaves headroom, so no word is offered while full
    a_no_write_full : assert property (@(posedge ap_clk) disable iff (areset_cu_setup)
        wr.valid |-> !full);

    // Word written while empty is at the output one cycle later
    a_fall_through : assert property (@(posedge ap_clk) disable iff (areset_cu_setup)
        (empty && wr_en) |=> rd_valid && (rd_data == $past(wr.payload)));

endmodule : request_fifo

// ==== hdl/serial_read_engine.sv ====
/*
 * Issues count requests from base, stride fixed at one word. Pause drops
 * valid, so it must only rise while the FIFO can still take a word.
 */
`include "cu_setup_consts.svh"

module serial_read_engine (
    input  logic                         ap_clk,
    input  logic                         areset_cu_setup,
    input  logic                         start,
    input  logic                         pause,
    input  logic [`CU_SETUP_ADDR_W-1:0]  base,
    input  logic [`CU_SETUP_COUNT_W-1:0] count,
    output logic                         engine_done,
    req_stream_if.source                 req
);

    localparam logic [`CU_SETUP_ADDR_W-1:0] ADDR_STEP =
        `CU_SETUP_ADDR_W'(1) << `CU_SETUP_WORD_SHIFT;

    logic [`CU_SETUP_ADDR_W-1:0]  addr_q;
    logic [`CU_SETUP_COUNT_W-1:0] idx_q;
    logic [`CU_SETUP_COUNT_W-1:0] count_q;
    logic                         xfer;

    // ----------------------------------------------------------------------
    // Request stream
    // ----------------------------------------------------------------------
    assign engine_done = (idx_q == count_q);
    assign req.valid   = !engine_done && !pause;
    assign req.payload = '{addr: addr_q, tag: idx_q};
    assign xfer        = req.valid && req.ready;

    // Word index and length
    always_ff @(posedge ap_clk) begin
        if (areset_cu_setup) begin
            idx_q   <= '0;
            count_q <= '0;
        end else if (start) begin
            idx_q   <= '0;
            count_q <= count;
        end else if (xfer) begin
            idx_q <= idx_q + 1'b1;
        end
    end

    // Address walks one word per transfer
    always_ff @(posedge ap_clk) begin
        if (start) begin
            addr_q <= base;
        end else if (xfer) begin
            addr_q <= addr_q + ADDR_STEP;
        end
    end

    // ----------------------------------------------------------------------
    // Assertions
    // ----------------------------------------------------------------------
    // After the last word transfers nothing further is offered
    a_no_extra_req : assert property (@(posedge ap_clk) disable iff (areset_cu_setup)
        (xfer && (idx_q + 1'b1 == count_q)) |=> !req.valid);

endmodule : serial_read_engine

// ==== hdl/setup_ctrl.sv ====
/*
 * One descriptor in flight at a time. desc_ready and setup_busy are registered,
 * so both need one clock after reset release to reach their idle values.
 */
`include "cu_setup_consts.svh"

module setup_ctrl (
    input  logic                         ap_clk,
    input  logic                         areset_cu_setup,
    input  logic                         desc_valid,
    output logic                         desc_ready,
    input  logic [`CU_SETUP_ADDR_W-1:0]  desc_base,
    input  logic [`CU_SETUP_COUNT_W-1:0] desc_count,
    output logic                         eng_start,
    output logic [`CU_SETUP_ADDR_W-1:0]  eng_base,
    output logic [`CU_SETUP_COUNT_W-1:0] eng_count,
    output logic                         eng_pause,
    input  logic                         engine_done,
    input  logic                         fifo_almost_full,
    input  logic                         fifo_empty,
    output logic                         setup_busy
);

    cu_setup_pkg::setup_state_t state;
    cu_setup_pkg::setup_state_t next_state;
    logic                       accept;

    assign accept    = desc_valid & desc_ready;
    assign eng_pause = (state == cu_setup_pkg::PAUSE);

    // ----------------------------------------------------------------------
    // Descriptor register
    // ----------------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (accept) begin
            eng_base  <= desc_base;
            eng_count <= desc_count;
        end
    end

    // ----------------------------------------------------------------------
    // Setup FSM
    // ----------------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_cu_setup) begin
            state <= cu_setup_pkg::IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            cu_setup_pkg::IDLE: begin
                if (accept) begin
                    next_state = cu_setup_pkg::START;
                end
            end
            cu_setup_pkg::START: begin
                next_state = cu_setup_pkg::BUSY;
            end
            cu_setup_pkg::BUSY: begin
                // Engine still shows the old done flag while start is high
                if (engine_done && !eng_start) begin
                    next_state = cu_setup_pkg::DRAIN;
                end else if (fifo_almost_full) begin
                    next_state = cu_setup_pkg::PAUSE;
                end
            end
            cu_setup_pkg::PAUSE: begin
                if (!fifo_almost_full) begin
                    next_state = cu_setup_pkg::BUSY;
                end
            end
            cu_setup_pkg::DRAIN: begin
                if (fifo_empty) begin
                    next_state = cu_setup_pkg::IDLE;
                end
            end
            default: begin
                next_state = cu_setup_pkg::IDLE;
            end
        endcase
    end

    // Registered handshake, status and start pulse
    always_ff @(posedge ap_clk) begin
        if (areset_cu_setup) begin
            desc_ready <= 1'b0;
            setup_busy <= 1'b1;
            eng_start  <= 1'b0;
        end else begin
            desc_ready <= (next_state == cu_setup_pkg::IDLE);
            setup_busy <= (next_state != cu_setup_pkg::IDLE);
            eng_start  <= (state == cu_setup_pkg::START);
        end
    end

    // ----------------------------------------------------------------------
    // Assertions
    // ----------------------------------------------------------------------
    // Start only reaches an idle engine and an empty FIFO
    a_start_when_idle : assert property (@(posedge ap_clk) disable iff (areset_cu_setup)
        eng_start |-> engine_done && fifo_empty);

    // New work only offered once the previous descriptor has drained
    a_ready_when_drained : assert property (@(posedge ap_clk) disable iff (areset_cu_setup)
        desc_ready |-> engine_done && fifo_empty);

endmodule : setup_ctrl

// ==== hdl/req_stream_if.sv ====
/*
 * Valid/ready request stream. Source holds payload until ready is seen.
 */
interface req_stream_if;

    logic                    valid;
    logic                    ready;
    cu_setup_pkg::read_req_t payload;

    // Read engine side
    modport source (
        output valid,
        output payload,
        input  ready
    );

    // FIFO write side
    modport sink (
        input  valid,
        input  payload,
        output ready
    );

endinterface : req_stream_if

// ==== hdl/cu_setup_pkg.sv ====
/*
 * Types of the setup stage. Widths come from the shared constants header.
 */
`include "cu_setup_consts.svh"

package cu_setup_pkg;

    // ----------------------------------------------------------------------
    // Control FSM states
    // ----------------------------------------------------------------------
    typedef enum logic [2:0] {
        IDLE  = 3'd0,
        START = 3'd1,
        BUSY  = 3'd2,
        PAUSE = 3'd3,
        DRAIN = 3'd4
    } setup_state_t;

    // ----------------------------------------------------------------------
    // One memory read request
    // ----------------------------------------------------------------------
    // Tag is the word index within the descriptor
    typedef struct packed {
        logic [`CU_SETUP_ADDR_W-1:0]  addr;
        logic [`CU_SETUP_COUNT_W-1:0] tag;
    } read_req_t;

endpackage : cu_setup_pkg

// ==== include/cu_setup_consts.svh ====
/*
 * Sizes shared by the compute-unit setup stage. The FIFO depth must exceed
 * the almost-full threshold by a few entries to absorb the pause latency.
 */
`ifndef CU_SETUP_CONSTS_SVH
`define CU_SETUP_CONSTS_SVH

// Byte address and word count widths
`define CU_SETUP_ADDR_W 32
`define CU_SETUP_COUNT_W 16

// log2 of bytes per word, one word per request
`define CU_SETUP_WORD_SHIFT 2

// Request FIFO sizing
`define CU_SETUP_FIFO_DEPTH 16
`define CU_SETUP_FIFO_THRESH 8

`endif
